/* logic/lbpTypesPkg.sv */
package lbpTypesPkg;

  // Gray value of one pixel.
  typedef logic [7:0] pixelT;

  // Interpolation coefficient in Q0.16.
  typedef logic [15:0] weightT;

  // Interpolated value in Q8.16.
  typedef logic [23:0] sampleT;

  // Bit k holds the sample at k * 45 degrees, counted counterclockwise.
  // Zero degrees points toward increasing column.
  typedef logic [7:0] codeT;

  // Column or row index within a frame.
  typedef logic [9:0] coordT;

  // Raster scanner states.
  typedef enum logic [1:0] {
    waitFrame,
    fillLines,
    streaming
  } scanStateT;

endpackage

/* logic/lbpGeometryPkg.sv */
package lbpGeometryPkg;
  import lbpTypesPkg::*;

  localparam int MinRadius = 2;
  localparam int MaxRadius = 8;

  // Signed row or column distance from the window center.
  typedef logic signed [4:0] offsetT;

  // Row offset in bits 9:5, column offset in bits 4:0.
  typedef logic [9:0] cellOriginT;

  ////////////////////
  // Coefficient table

  // Each radius has three distinct weights p, q and r.
  // The angle decides which of them lands on which corner.
  function automatic weightT cornerWeight(int radius, int angle, int corner);
    logic [47:0] triple;
    logic [7:0]  sel;
    logic [1:0]  pick;
    case (radius)
      2:       triple = {16'h3E1D, 16'h57D8, 16'h2BEC};
      3:       triple = {16'h1B4A, 16'hC5A6, 16'h03C4};
      4:       triple = {16'h2463, 16'h0789, 16'hAFB0};
      5:       triple = {16'h3FAD, 16'h3739, 16'h496B};
      6:       triple = {16'h2F0B, 16'h92D6, 16'h0F12};
      7:       triple = {16'h0C37, 16'h00A5, 16'hE6EA};
      8:       triple = {16'h39B3, 16'h1E24, 16'h6E73};
      default: triple = '0;
    endcase
    // Corner 0 sits in the top two bits. Selector 0 is p, 1 is q and 2 is r.
    case (angle)
      45:      sel = {2'd0, 2'd2, 2'd1, 2'd0};
      135:     sel = {2'd2, 2'd0, 2'd0, 2'd1};
      225:     sel = {2'd0, 2'd1, 2'd2, 2'd0};
      315:     sel = {2'd1, 2'd0, 2'd0, 2'd2};
      default: sel = '0;
    endcase
    pick = sel[6 - 2 * corner +: 2];
    return triple[47 - 16 * pick -: 16];
  endfunction

  // The four truncated weights of a cell sum to slightly less than one.
  function automatic weightT unityWeight(int radius, int angle);
    int sum;
    sum = 0;
    for (int k = 0; k < 4; k++) begin
      sum += int'(cornerWeight(radius, angle, k));
    end
    return weightT'(sum);
  endfunction

  ////////////////////
  // Diagonal cells

  function automatic cellOriginT cellOrigin(int radius, int angle);
    int reach;
    int rowOff;
    int colOff;
    // Floor of radius * cos 45.
    case (radius)
      2:       reach = 1;
      3, 4:    reach = 2;
      5:       reach = 3;
      6, 7:    reach = 4;
      default: reach = 5;
    endcase
    // Rows grow downward, so a positive sine moves up.
    case (angle)
      45: begin
        rowOff = -(reach + 1);
        colOff = reach;
      end
      135: begin
        rowOff = -(reach + 1);
        colOff = -(reach + 1);
      end
      225: begin
        rowOff = reach;
        colOff = -(reach + 1);
      end
      default: begin
        rowOff = reach;
        colOff = reach;
      end
    endcase
    return {offsetT'(rowOff), offsetT'(colOff)};
  endfunction

endpackage

/* logic/lbpWindowIf.sv */
`timescale 1ns/1ns

interface lbpWindowIf import lbpTypesPkg::*; #(
  parameter int Radius      = 2,
  parameter int ImageWidth  = 16,
  parameter int ImageHeight = 12
) (
  input logic clk,
  input logic rst_n
);

  localparam int WinSize = 2 * Radius + 1;

  // Row 0 is the top line and column 0 the leftmost pixel.
  pixelT [WinSize-1:0][WinSize-1:0] window;
  logic  windowValid;
  coordT centerCol;
  coordT centerRow;

  modport source (output window, windowValid, centerCol, centerRow);
  modport sink (input window, windowValid);

  // The scanner only marks windows whose neighborhood lies inside the frame.
  assert property (@(posedge clk) disable iff (!rst_n)
    windowValid |-> centerCol >= coordT'(Radius)
                 && centerCol < coordT'(ImageWidth - Radius)
                 && centerRow >= coordT'(Radius)
                 && centerRow < coordT'(ImageHeight - Radius))
    else $error("window centered outside the image interior");

endinterface

/* logic/rasterScanner.sv */
`timescale 1ns/1ns

module rasterScanner import lbpTypesPkg::*; #(
  parameter int Radius      = 2,
  parameter int ImageWidth  = 16,
  parameter int ImageHeight = 12
) (
  input  logic  clk,
  input  logic  rst_n,
  input  logic  pixelValid,
  input  pixelT pixel,
  input  logic  frameStart,
  output logic  scanValid,
  output pixelT scanPixel,
  output logic  windowReady,
  output coordT col,
  output coordT row
);

  localparam coordT LastCol = coordT'(ImageWidth - 1);
  localparam coordT LastRow = coordT'(ImageHeight - 1);
  localparam coordT Span    = coordT'(2 * Radius);

  scanStateT state;
  coordT     colCnt;
  coordT     rowCnt;
  logic      accept;

  // A frameStart pixel is always at (0, 0), whatever the counters hold.
  assign col    = frameStart ? '0 : colCnt;
  assign row    = frameStart ? '0 : rowCnt;
  assign accept = pixelValid && (frameStart || state != waitFrame);

  assign scanValid   = accept;
  assign scanPixel   = pixel;
  assign windowReady = accept && !frameStart && state == streaming && col >= Span;

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      state  <= waitFrame;
      colCnt <= '0;
      rowCnt <= '0;
    end else if (accept) begin
      if (col == LastCol) begin
        colCnt <= '0;
        rowCnt <= row + 1'b1;
        if (row == LastRow) begin
          state <= waitFrame;
        end else if (row + 1'b1 >= Span) begin
          state <= streaming;
        end else begin
          state <= fillLines;
        end
      end else begin
        colCnt <= col + 1'b1;
        if (frameStart) begin
          rowCnt <= '0;
          state  <= fillLines;
        end
      end
    end
  end

  // Pixels beyond the last row need a new frameStart first.
  assert property (@(posedge clk) disable iff (!rst_n)
    pixelValid && !frameStart |-> rowCnt <= LastRow)
    else $error("pixel arrived past the last image row without a frameStart");

endmodule

/* logic/lineWindowBuffer.sv */
`timescale 1ns/1ns

module lineWindowBuffer import lbpTypesPkg::*; #(
  parameter int Radius     = 2,
  parameter int ImageWidth = 16
) (
  input  logic       clk,
  input  logic       rst_n,
  input  logic       scanValid,
  input  pixelT      scanPixel,
  input  logic       windowReady,
  input  coordT      col,
  input  coordT      row,
  lbpWindowIf.source win
);

  localparam int Lines    = 2 * Radius;
  localparam int WinSize  = 2 * Radius + 1;
  localparam int AddrBits = $clog2(ImageWidth);

  // Line 0 holds the oldest row, line Lines-1 the row just above the input.
  pixelT lineMem [Lines][ImageWidth];

  logic [AddrBits-1:0] addr;
  pixelT [WinSize-1:0] newColumn;

  assign addr = col[AddrBits-1:0];

  // The column entering the window, top row first and the new pixel last.
  always_comb begin
    for (int k = 0; k < Lines; k++) begin
      newColumn[k] = lineMem[k][addr];
    end
    newColumn[Lines] = scanPixel;
  end

  ////////////////////
  // Line memories

  // Every line moves up by one at this column.
  always_ff @(posedge clk) begin
    if (scanValid) begin
      for (int k = 0; k < Lines; k++) begin
        lineMem[k][addr] <= newColumn[k + 1];
      end
    end
  end

  ////////////////////
  // Register window

  always_ff @(posedge clk) begin
    if (scanValid) begin
      for (int r = 0; r < WinSize; r++) begin
        for (int c = 0; c < WinSize - 1; c++) begin
          win.window[r][c] <= win.window[r][c + 1];
        end
        win.window[r][WinSize - 1] <= newColumn[r];
      end
    end
  end

  always_ff @(posedge clk) begin
    if (windowReady) begin
      win.centerCol <= col - coordT'(Radius);
      win.centerRow <= row - coordT'(Radius);
    end
  end

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      win.windowValid <= 1'b0;
    end else begin
      win.windowValid <= windowReady;
    end
  end

endmodule

/* logic/interpolationCalc.sv */
`timescale 1ns/1ns

module interpolationCalc import lbpTypesPkg::*, lbpGeometryPkg::*; #(
  parameter int Radius = 2,
  parameter int Angle  = 45
) (
  input  logic   clk,
  input  logic   rst_n,
  input  pixelT  a,
  input  pixelT  b,
  input  pixelT  c,
  input  pixelT  d,
  output sampleT sample
);

  // A gets (1-dx)(1-dy), B gets dx(1-dy), C gets (1-dx)dy and D gets dx*dy.
  localparam weightT WeightA = cornerWeight(Radius, Angle, 0);
  localparam weightT WeightB = cornerWeight(Radius, Angle, 1);
  localparam weightT WeightC = cornerWeight(Radius, Angle, 2);
  localparam weightT WeightD = cornerWeight(Radius, Angle, 3);

  sampleT productA;
  sampleT productB;
  sampleT productC;
  sampleT productD;
  sampleT sumAB;
  sampleT sumCD;

  // Multiply, pair sums, final sum. One new sample may enter every cycle.
  always_ff @(posedge clk) begin
    productA <= sampleT'(WeightA) * sampleT'(a);
    productB <= sampleT'(WeightB) * sampleT'(b);
    productC <= sampleT'(WeightC) * sampleT'(c);
    productD <= sampleT'(WeightD) * sampleT'(d);
    sumAB    <= productA + productB;
    sumCD    <= productC + productD;
    sample   <= sumAB + sumCD;
  end

  // The weight table only covers these radii and the four diagonals.
  assert property (@(posedge clk) disable iff (!rst_n)
    Radius >= MinRadius && Radius <= MaxRadius
    && (Angle == 45 || Angle == 135 || Angle == 225 || Angle == 315))
    else $error("interpolator built for an unsupported radius or angle");

endmodule

/* logic/lbpEncoder.sv */
`timescale 1ns/1ns

module lbpEncoder import lbpTypesPkg::*, lbpGeometryPkg::*; #(
  parameter int Radius = 2
) (
  input  logic     clk,
  input  logic     rst_n,
  lbpWindowIf.sink win,
  output logic     codeValid,
  output codeT     code
);

  // Matches the interpolator pipeline.
  localparam int Depth = 3;

  pixelT       center;
  pixelT [3:0] whole;
  sampleT      diagSample [4];
  sampleT      diagRef [4];
  pixelT       centerDly [Depth];
  pixelT [3:0] wholeDly [Depth];
  logic [Depth-1:0] validDly;
  codeT        nextCode;

  // Whole pixels at 0, 90, 180 and 270 degrees. Up is a smaller row index.
  assign center   = win.window[Radius][Radius];
  assign whole[0] = win.window[Radius][2 * Radius];
  assign whole[1] = win.window[0][Radius];
  assign whole[2] = win.window[Radius][0];
  assign whole[3] = win.window[2 * Radius][Radius];

  ////////////////////
  // Diagonal samples

  for (genvar k = 0; k < 4; k++) begin : gDiag
    localparam int         Angle  = 45 + 90 * k;
    localparam cellOriginT Origin = cellOrigin(Radius, Angle);
    localparam int         RowA   = Radius + int'(offsetT'(Origin[9:5]));
    localparam int         ColA   = Radius + int'(offsetT'(Origin[4:0]));
    localparam weightT     Unity  = unityWeight(Radius, Angle);

    interpolationCalc #(
      .Radius(Radius),
      .Angle (Angle)
    ) uInterp (
      .clk   (clk),
      .rst_n (rst_n),
      .a     (win.window[RowA][ColA]),
      .b     (win.window[RowA][ColA + 1]),
      .c     (win.window[RowA + 1][ColA]),
      .d     (win.window[RowA + 1][ColA + 1]),
      .sample(diagSample[k])
    );

    // The center is scaled by the cell's own weight sum, so a flat area sets the bit.
    assign diagRef[k] = sampleT'(centerDly[Depth - 1]) * sampleT'(Unity);
  end

  ////////////////////
  // Alignment and compare

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      validDly <= '0;
    end else begin
      validDly <= {validDly[Depth-2:0], win.windowValid};
    end
  end

  always_ff @(posedge clk) begin
    centerDly[0] <= center;
    wholeDly[0]  <= whole;
    for (int i = 1; i < Depth; i++) begin
      centerDly[i] <= centerDly[i - 1];
      wholeDly[i]  <= wholeDly[i - 1];
    end
  end

  // Even bits come from whole pixels, odd bits from the diagonals.
  always_comb begin
    for (int k = 0; k < 4; k++) begin
      nextCode[2 * k]     = wholeDly[Depth - 1][k] >= centerDly[Depth - 1];
      nextCode[2 * k + 1] = diagSample[k] >= diagRef[k];
    end
  end

  always_ff @(posedge clk) begin
    code <= nextCode;
    if (!rst_n) begin
      codeValid <= 1'b0;
    end else begin
      codeValid <= validDly[Depth - 1];
    end
  end

  // Every code traces back to a window presented four cycles earlier.
  assert property (@(posedge clk) disable iff (!rst_n)
    codeValid |-> $past(win.windowValid, Depth + 1))
    else $error("code emitted without a matching window");

endmodule

/* logic/lbpTop.sv */
`timescale 1ns/1ns

module lbpTop import lbpTypesPkg::*; #(
  parameter int Radius      = 2,
  parameter int ImageWidth  = 16,
  parameter int ImageHeight = 12
) (
  input  logic  clk,
  input  logic  rst_n,
  input  logic  pixelValid,
  input  pixelT pixel,
  input  logic  frameStart,
  output logic  codeValid,
  output codeT  code
);

  logic  scanValid;
  pixelT scanPixel;
  logic  windowReady;
  coordT col;
  coordT row;

  lbpWindowIf #(
    .Radius     (Radius),
    .ImageWidth (ImageWidth),
    .ImageHeight(ImageHeight)
  ) winIf (
    .clk  (clk),
    .rst_n(rst_n)
  );

  rasterScanner #(
    .Radius     (Radius),
    .ImageWidth (ImageWidth),
    .ImageHeight(ImageHeight)
  ) uScanner (
    .clk        (clk),
    .rst_n      (rst_n),
    .pixelValid (pixelValid),
    .pixel      (pixel),
    .frameStart (frameStart),
    .scanValid  (scanValid),
    .scanPixel  (scanPixel),
    .windowReady(windowReady),
    .col        (col),
    .row        (row)
  );

  lineWindowBuffer #(
    .Radius    (Radius),
    .ImageWidth(ImageWidth)
  ) uBuffer (
    .clk        (clk),
    .rst_n      (rst_n),
    .scanValid  (scanValid),
    .scanPixel  (scanPixel),
    .windowReady(windowReady),
    .col        (col),
    .row        (row),
    .win        (winIf.source)
  );

  lbpEncoder #(
    .Radius(Radius)
  ) uEncoder (
    .clk      (clk),
    .rst_n    (rst_n),
    .win      (winIf.sink),
    .codeValid(codeValid),
    .code     (code)
  );

endmodule

/* testbench/clockGen.sv */
`timescale 1ns/1ns

module clockGen #(
  parameter int HalfPeriod  = 4,
  parameter int ResetCycles = 16
) (
  output logic clk,
  output logic rst_n
);

  initial begin
    clk = 1'b0;
    forever #HalfPeriod clk = ~clk;
  end

  // Reset is released a nanosecond after an edge, like every other input.
  initial begin
    rst_n = 1'b0;
    repeat (ResetCycles) @(posedge clk);
    #1 rst_n = 1'b1;
  end

endmodule

/* testbench/lbpTb.sv */
`timescale 1ns/1ns

module lbpTb import lbpTypesPkg::*, lbpGeometryPkg::*; ();

  localparam int Radius      = 2;
  localparam int ImageWidth  = 16;
  localparam int ImageHeight = 12;
  localparam int FullFrame   = ImageWidth * ImageHeight;
  localparam int FullCodes   = (ImageWidth - 2 * Radius) * (ImageHeight - 2 * Radius);
  localparam int NumFrames   = 7;
  localparam int DrainCycles = 6;

  typedef enum logic [2:0] {patFlat, patHRamp, patVRamp, patChecker, patNoise} patternT;

  typedef struct packed {
    patternT kind;
    pixelT   arg;
    int      pixels;
    int      codes;
  } frameRowT;

  // The first noise frame stops after seven rows, so the next frameStart arrives mid-frame.
  frameRowT frames [NumFrames] = '{
    '{patFlat,    8'h5A, FullFrame,      FullCodes},
    '{patHRamp,   8'd3,  FullFrame,      FullCodes},
    '{patVRamp,   8'd7,  FullFrame,      FullCodes},
    '{patChecker, 8'hC8, FullFrame,      FullCodes},
    '{patNoise,   8'h00, 7 * ImageWidth, 3 * (ImageWidth - 2 * Radius)},
    '{patNoise,   8'h00, FullFrame,      FullCodes},
    '{patFlat,    8'h00, FullFrame,      FullCodes}
  };

  logic  clk;
  logic  rst_n;
  logic  pixelValid;
  pixelT pixel;
  logic  frameStart;
  logic  codeValid;
  codeT  code;

  logic [31:0] lfsr = 32'h88a9;
  pixelT       img [ImageHeight][ImageWidth];
  codeT        expQ [$];
  int          curFrame = 0;
  int          gotCount = 0;
  int          codeErrors = 0;
  int          countErrors = 0;
  int          otherErrors = 0;

  clockGen clocks (
    .clk  (clk),
    .rst_n(rst_n)
  );

  lbpTop dut (
    .clk       (clk),
    .rst_n     (rst_n),
    .pixelValid(pixelValid),
    .pixel     (pixel),
    .frameStart(frameStart),
    .codeValid (codeValid),
    .code      (code)
  );

  ////////////////////
  // Stimulus

  function automatic logic nextBit();
    logic out;
    out  = lfsr[0];
    lfsr = lfsr >> 1;
    if (out) begin
      lfsr = lfsr ^ 32'h8020_0003;
    end
    return out;
  endfunction

  function automatic pixelT takeBits(int count);
    pixelT bits;
    bits = '0;
    for (int i = 0; i < count; i++) begin
      bits = {bits[6:0], nextBit()};
    end
    return bits;
  endfunction

  function automatic void fillImage(patternT kind, pixelT arg);
    for (int r = 0; r < ImageHeight; r++) begin
      for (int c = 0; c < ImageWidth; c++) begin
        case (kind)
          patHRamp:   img[r][c] = pixelT'(16 + c * arg);
          patVRamp:   img[r][c] = pixelT'(16 + r * arg);
          patChecker: img[r][c] = ((r + c) % 2 == 1) ? arg : ~arg;
          patNoise:   img[r][c] = takeBits(8);
          default:    img[r][c] = arg;
        endcase
      end
    end
  endfunction

  function automatic int totalPixels();
    int sum;
    sum = 0;
    for (int i = 0; i < NumFrames; i++) begin
      sum += frames[i].pixels;
    end
    return sum;
  endfunction

  ////////////////////
  // Reference model

  // Whole pixels sit at distance Radius; diagonals use the truncated table weights.
  function automatic codeT modelCode(int cr, int cc);
    codeT       result;
    pixelT      center;
    cellOriginT origin;
    int         angle;
    int         ra;
    int         ca;
    int         w;
    int         acc;
    int         unity;
    pixelT      corner [4];
    center    = img[cr][cc];
    result[0] = img[cr][cc + Radius] >= center;
    result[2] = img[cr - Radius][cc] >= center;
    result[4] = img[cr][cc - Radius] >= center;
    result[6] = img[cr + Radius][cc] >= center;
    for (int k = 0; k < 4; k++) begin
      angle     = 45 + 90 * k;
      origin    = cellOrigin(Radius, angle);
      ra        = cr + $signed(origin[9:5]);
      ca        = cc + $signed(origin[4:0]);
      corner[0] = img[ra][ca];
      corner[1] = img[ra][ca + 1];
      corner[2] = img[ra + 1][ca];
      corner[3] = img[ra + 1][ca + 1];
      acc   = 0;
      unity = 0;
      for (int j = 0; j < 4; j++) begin
        w     = int'(cornerWeight(Radius, angle, j));
        acc   += w * int'(corner[j]);
        unity += w;
      end
      unity = unity % 65536;
      result[2 * k + 1] = acc >= int'(center) * unity;
    end
    return result;
  endfunction

  function automatic int queueExpected(int pixels);
    int n;
    int r;
    int c;
    n = 0;
    for (int p = 0; p < pixels; p++) begin
      r = p / ImageWidth;
      c = p % ImageWidth;
      if (r >= 2 * Radius && c >= 2 * Radius) begin
        expQ.push_back(modelCode(r - Radius, c - Radius));
        n++;
      end
    end
    return n;
  endfunction

  ////////////////////
  // Checks

  task automatic checkCode(codeT got, codeT exp, int index);
    if (got !== exp) begin
      codeErrors++;
      $display("ERR %0t: frame %0d code %0d is %02h, expected %02h",
               $time, curFrame, index, got, exp);
    end
  endtask

  task automatic checkCount(coordT got, coordT exp, int frame);
    if (got !== exp) begin
      countErrors++;
      $display("ERR %0t: frame %0d gave %0d codes, expected %0d", $time, frame, got, exp);
    end
  endtask

  always @(negedge clk) begin
    if (codeValid === 1'b1) begin
      if (expQ.size() == 0) begin
        otherErrors++;
        $display("Code %02h appeared at %0t while no window was pending", code, $time);
      end else begin
        checkCode(code, expQ.pop_front(), gotCount);
      end
      gotCount++;
    end
  end

  task automatic driveCycle(logic valid, pixelT value, logic first);
    @(posedge clk);
    #1;
    pixelValid = valid;
    pixel      = value;
    frameStart = first;
  endtask

  task automatic playFrame(int index);
    frameRowT entry;
    int       expected;
    entry    = frames[index];
    curFrame = index;
    fillImage(entry.kind, entry.arg);
    expected = queueExpected(entry.pixels);
    gotCount = 0;
    for (int p = 0; p < entry.pixels; p++) begin
      // Noise frames idle for a cycle whenever two LFSR bits are both set.
      if (entry.kind == patNoise) begin
        while (takeBits(2) == 8'd3) begin
          driveCycle(1'b0, '0, 1'b0);
        end
      end
      driveCycle(1'b1, img[p / ImageWidth][p % ImageWidth], p == 0);
    end
    driveCycle(1'b0, '0, 1'b0);
    while (gotCount < expected) begin
      @(negedge clk);
    end
    repeat (DrainCycles) @(negedge clk);
    checkCount(coordT'(gotCount), coordT'(entry.codes), index);
  endtask

  initial begin
    pixelValid = 1'b0;
    pixel      = '0;
    frameStart = 1'b0;
    @(posedge rst_n);
    repeat (4) driveCycle(1'b0, '0, 1'b0);
    for (int i = 0; i < NumFrames; i++) begin
      playFrame(i);
    end
    $display("errors: %0d code, %0d count, %0d other", codeErrors, countErrors, otherErrors);
    if (codeErrors + countErrors + otherErrors == 0) begin
      $display("TEST OK");
    end else begin
      $display("TEST FAILED");
    end
    $finish;
  end

  initial begin
    int cycles;
    int limit;
    cycles = 0;
    limit  = 20 + 2 * totalPixels();
    while (cycles < limit) begin
      @(posedge clk);
      cycles++;
    end
    $display("The run timed out after %0d cycles in frame %0d", cycles, curFrame);
    $display("TEST FAILED");
    $finish;
  end

endmodule

/* list.f */
logic/lbpTypesPkg.sv
logic/lbpGeometryPkg.sv
logic/lbpWindowIf.sv
logic/rasterScanner.sv
logic/lineWindowBuffer.sv
logic/interpolationCalc.sv
logic/lbpEncoder.sv
logic/lbpTop.sv
testbench/clockGen.sv
testbench/lbpTb.sv

/* Makefile */
.PHONY: all lint clean

all:
	verilator --binary --timing --assert -Wno-fatal -f list.f --top-module lbpTb \
		-Mdir obj_dir -o lbpSim
	obj_dir/lbpSim | tee sim.log
	grep -qx "TEST OK" sim.log

lint:
	verilator --lint-only --timing -Wall -f list.f --top-module lbpTb

clean:
	rm -rf obj_dir sim.log
